// File: source/axi_pkg.sv
/*
 * AXI4 widths and encodings used by the burst front end and the subsystem top.
 * Only FIXED, INCR and WRAP bursts are defined.
 * Only OKAY and SLVERR responses are defined.
 * User, lock, cache, protection and QoS fields are not carried.
 */
`default_nettype none

package axi_pkg;

    localparam int AXI_ADDR_BITS = 16;
    localparam int AXI_DATA_BITS = 32;
    localparam int AXI_STRB_BITS = AXI_DATA_BITS / 8;
    localparam int AXI_ID_BITS   = 4;

    // AxBURST encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    // xRESP encoding, EXOKAY and DECERR never produced
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // Bytes moved by one beat for an AxSIZE code
    function automatic logic [7:0] size_to_bytes(input logic [2:0] size);
        return 8'd1 << size;
    endfunction

endpackage

`default_nettype wire

// File: source/sysbus_pkg.sv
/*
 * Single-beat system bus between the AXI front end and memory targets.
 * Addresses are byte addresses. A target answers every accepted request once.
 */
`default_nettype none

package sysbus_pkg;

    localparam int SYS_ADDR_BITS = 16;
    localparam int SYS_DATA_BITS = 32;
    localparam int SYS_STRB_BITS = SYS_DATA_BITS / 8;

    typedef struct packed {
        logic [SYS_ADDR_BITS-1:0] addr;   // Byte address of the beat
        logic                     write;
        logic [SYS_DATA_BITS-1:0] wdata;
        logic [SYS_STRB_BITS-1:0] wstrb;
        logic                     last;   // Final beat of the AXI burst
    } sys_req_t;

    typedef struct packed {
        logic [SYS_DATA_BITS-1:0] rdata;
        logic                     err;    // Target could not serve the beat
    } sys_resp_t;

endpackage

`default_nettype wire

// File: source/sysbus_if.sv
/*
 * Request and response wires of the system bus.
 * The target answers one cycle after each accepted request and cannot stall it.
 */
`default_nettype none

interface sysbus_if;
    import axi_pkg::*;
    import sysbus_pkg::*;

    logic      req_valid;
    sys_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    sys_resp_t resp;

    // Each AXI beat must map onto exactly one bus word
    if (SYS_DATA_BITS != AXI_DATA_BITS || SYS_STRB_BITS != AXI_STRB_BITS) begin : g_width_check
        $error("sysbus data width does not match the AXI data width");
    end

    modport master (
        output req_valid, req,
        input  req_ready, resp_valid, resp
    );

    modport target (
        input  req_valid, req,
        output req_ready, resp_valid, resp
    );

endinterface

`default_nettype wire

// File: source/axi_burst_slave.sv
/*
 * AXI4 burst slave that splits bursts into single-beat system-bus requests.
 * One transaction at a time. AW wins over AR in the same cycle.
 * W data must not lead AW. A W beat offered alone in idle is dropped.
 * The write burst ends on WLAST. Beat addresses stay inside the 4 KB page.
 * WRAP bursts expect len of 1, 3, 7 or 15. All handshakes are held off
 * for one cycle after reset.
 */
`default_nettype none

module axi_burst_slave (
    input  wire logic                              i_clk,
    input  wire logic                              i_nrst,
    input  wire logic                              i_awvalid,
    input  wire logic [axi_pkg::AXI_ADDR_BITS-1:0] i_awaddr,
    input  wire logic [7:0]                        i_awlen,
    input  wire logic [2:0]                        i_awsize,
    input  wire axi_pkg::axi_burst_t               i_awburst,
    input  wire logic [axi_pkg::AXI_ID_BITS-1:0]   i_awid,
    output logic                                   o_awready,
    input  wire logic                              i_wvalid,
    input  wire logic [axi_pkg::AXI_DATA_BITS-1:0] i_wdata,
    input  wire logic [axi_pkg::AXI_STRB_BITS-1:0] i_wstrb,
    input  wire logic                              i_wlast,
    output logic                                   o_wready,
    output logic                                   o_bvalid,
    output axi_pkg::axi_resp_t                     o_bresp,
    output logic [axi_pkg::AXI_ID_BITS-1:0]        o_bid,
    input  wire logic                              i_bready,
    input  wire logic                              i_arvalid,
    input  wire logic [axi_pkg::AXI_ADDR_BITS-1:0] i_araddr,
    input  wire logic [7:0]                        i_arlen,
    input  wire logic [2:0]                        i_arsize,
    input  wire axi_pkg::axi_burst_t               i_arburst,
    input  wire logic [axi_pkg::AXI_ID_BITS-1:0]   i_arid,
    output logic                                   o_arready,
    output logic                                   o_rvalid,
    output logic [axi_pkg::AXI_DATA_BITS-1:0]      o_rdata,
    output axi_pkg::axi_resp_t                     o_rresp,
    output logic [axi_pkg::AXI_ID_BITS-1:0]        o_rid,
    output logic                                   o_rlast,
    input  wire logic                              i_rready,
    sysbus_if.master                               bus
);
    import axi_pkg::*;
    import sysbus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_WR_WAIT, ST_WR_BEAT, ST_WR_RESP, ST_RD_ADDR, ST_RD_DATA, ST_RD_OUT
    } state_t;

    state_t                   state_q;
    logic                     live_q;      // Low in the first cycle out of reset
    logic [AXI_ADDR_BITS-1:0] addr_q;      // Address of the next request
    logic [7:0]               xbytes_q;
    logic [7:0]               len_q;
    axi_burst_t               burst_q;
    logic [AXI_ID_BITS-1:0]   id_q;
    logic [7:0]               beat_q;      // Read requests accepted so far
    logic                     wr_valid_q;
    logic [AXI_DATA_BITS-1:0] wdata_q;
    logic [AXI_STRB_BITS-1:0] wstrb_q;
    logic                     wlast_q;
    logic                     err_q;       // Sticky over the write burst
    logic                     bvalid_q;
    logic                     inflight_q;  // Read response lands this cycle
    logic                     pend_last_q;
    logic                     rvalid_q;
    logic [AXI_DATA_BITS-1:0] rdata_q;
    logic                     rerr_q;
    logic                     rlast_q;

    logic [15:0]              wrap_bytes;
    logic [11:0]              wrap_mask;
    logic [11:0]              page_next;
    logic                     req_fire;
    logic                     aw_fire;
    logic                     ar_fire;
    logic                     w_fire;
    logic                     rd_last;
    logic                     rd_issue;

    // Next beat address, only the low 12 bits ever move
    always_comb begin
        wrap_bytes = 16'(xbytes_q) * (16'(len_q) + 16'd1);
        wrap_mask  = 12'(wrap_bytes - 16'd1);
        page_next  = addr_q[11:0] + 12'(xbytes_q);
        if (burst_q == BURST_FIXED) begin
            page_next = addr_q[11:0];
        end else if (burst_q == BURST_WRAP) begin
            page_next = (addr_q[11:0] & ~wrap_mask) | (page_next & wrap_mask);
        end
    end

    assign req_fire = bus.req_valid && bus.req_ready;
    assign aw_fire  = o_awready && i_awvalid;
    assign ar_fire  = o_arready && i_arvalid;
    assign w_fire   = o_wready && i_wvalid;
    assign rd_last  = (beat_q == len_q);

    // A read beat goes out only if its response will find the R register free
    assign rd_issue = (state_q == ST_RD_ADDR) && !inflight_q && (!rvalid_q || i_rready);

    assign o_awready = live_q && (state_q == ST_IDLE);
    assign o_arready = live_q && (state_q == ST_IDLE) && !i_awvalid;   // Writes first

    always_comb begin
        case (state_q)
            ST_IDLE, ST_WR_WAIT: o_wready = live_q;
            ST_WR_BEAT:          o_wready = bus.req_ready;   // Next beat rides the handoff
            default:             o_wready = 1'b0;
        endcase
    end

    assign bus.req_valid = wr_valid_q || rd_issue;
    assign bus.req = '{
        addr:  SYS_ADDR_BITS'(addr_q),
        write: (state_q == ST_WR_BEAT),
        wdata: SYS_DATA_BITS'(wdata_q),
        wstrb: SYS_STRB_BITS'(wstrb_q),
        last:  (state_q == ST_RD_ADDR) ? rd_last : wlast_q
    };

    assign o_bvalid = bvalid_q;
    assign o_bresp  = err_q ? RESP_SLVERR : RESP_OKAY;
    assign o_bid    = id_q;
    assign o_rvalid = rvalid_q;
    assign o_rdata  = rdata_q;
    assign o_rresp  = rerr_q ? RESP_SLVERR : RESP_OKAY;
    assign o_rid    = id_q;
    assign o_rlast  = rlast_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q    <= ST_IDLE;
            live_q     <= 1'b0;
            wr_valid_q <= 1'b0;
            err_q      <= 1'b0;
            bvalid_q   <= 1'b0;
            inflight_q <= 1'b0;
            rvalid_q   <= 1'b0;
            beat_q     <= '0;
        end else begin
            live_q     <= 1'b1;
            inflight_q <= rd_issue && bus.req_ready;
            if (bus.resp_valid && bus.resp.err) begin
                err_q <= 1'b1;
            end
            // A landing response refills R even while it drains
            if (inflight_q && bus.resp_valid) begin
                rvalid_q <= 1'b1;
            end else if (i_rready) begin
                rvalid_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (aw_fire) begin
                        err_q      <= 1'b0;
                        wr_valid_q <= i_wvalid;
                        state_q    <= i_wvalid ? ST_WR_BEAT : ST_WR_WAIT;
                    end else if (ar_fire) begin
                        beat_q  <= '0;
                        state_q <= ST_RD_ADDR;
                    end
                end
                ST_WR_WAIT: begin
                    if (w_fire) begin
                        wr_valid_q <= 1'b1;
                        state_q    <= ST_WR_BEAT;
                    end
                end
                ST_WR_BEAT: begin
                    if (req_fire && wlast_q) begin
                        wr_valid_q <= 1'b0;
                        state_q    <= ST_WR_RESP;
                    end else if (w_fire) begin
                        wr_valid_q <= 1'b1;
                    end else if (req_fire) begin
                        wr_valid_q <= 1'b0;
                    end
                end
                ST_WR_RESP: begin
                    if (bvalid_q && i_bready) begin
                        bvalid_q <= 1'b0;
                        state_q  <= ST_IDLE;
                    end else if (bus.resp_valid) begin
                        bvalid_q <= 1'b1;   // Last beat answered
                    end
                end
                ST_RD_ADDR: begin
                    if (req_fire) begin
                        beat_q <= beat_q + 8'd1;
                        if (rd_last) begin
                            state_q <= ST_RD_DATA;
                        end
                    end
                end
                ST_RD_DATA: begin
                    if (bus.resp_valid) begin
                        state_q <= ST_RD_OUT;
                    end
                end
                ST_RD_OUT: begin
                    if (rvalid_q && i_rready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Burst attributes, write beat and R payload
    always_ff @(posedge i_clk) begin
        if (aw_fire) begin
            addr_q   <= i_awaddr;
            xbytes_q <= size_to_bytes(i_awsize);
            len_q    <= i_awlen;
            burst_q  <= i_awburst;
            id_q     <= i_awid;
        end else if (ar_fire) begin
            addr_q   <= i_araddr;
            xbytes_q <= size_to_bytes(i_arsize);
            len_q    <= i_arlen;
            burst_q  <= i_arburst;
            id_q     <= i_arid;
        end else if (req_fire) begin
            addr_q <= {addr_q[AXI_ADDR_BITS-1:12], page_next};
        end
        if (w_fire) begin
            wdata_q <= i_wdata;
            wstrb_q <= i_wstrb;
            wlast_q <= i_wlast;
        end
        if (req_fire) begin
            pend_last_q <= bus.req.last;
        end
        if (inflight_q && bus.resp_valid) begin
            rdata_q <= AXI_DATA_BITS'(bus.resp.rdata);
            rerr_q  <= bus.resp.err;
            rlast_q <= pend_last_q;
        end
    end

endmodule

`default_nettype wire

// File: source/sram_target.sv
/*
 * Word-addressed SRAM on the system bus with byte write strobes.
 * Never stalls. Answers every request in the next cycle.
 * Words at MEM_WORDS and above return err, ignore writes and read as zero.
 * Write responses carry zero data.
 */
`default_nettype none

module sram_target #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    sysbus_if.target  bus
);
    import axi_pkg::*;
    import sysbus_pkg::*;

    localparam int IDX_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int LSB      = $clog2(SYS_STRB_BITS);   // Byte offset bits in a word

    // Words past the AXI window could never be reached
    if (MEM_WORDS * AXI_STRB_BITS > (1 << AXI_ADDR_BITS)) begin : g_depth_check
        $error("MEM_WORDS exceeds the AXI address range");
    end

    logic [SYS_DATA_BITS-1:0] mem [MEM_WORDS];
    logic [31:0]              word_addr;
    logic [IDX_BITS-1:0]      idx;
    logic                     hit;
    logic                     req_fire;
    logic                     resp_valid_q;
    sys_resp_t                resp_q;

    assign bus.req_ready = 1'b1;
    assign req_fire      = bus.req_valid && bus.req_ready;
    assign word_addr     = 32'(bus.req.addr >> LSB);
    assign idx           = word_addr[IDX_BITS-1:0];
    assign hit           = (word_addr < 32'(MEM_WORDS));

    // Byte lanes written only where the strobe is set
    always_ff @(posedge i_clk) begin
        if (req_fire && bus.req.write && hit) begin
            for (int b = 0; b < SYS_STRB_BITS; b++) begin
                if (bus.req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= bus.req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            resp_q.err   <= !hit;
            resp_q.rdata <= (hit && !bus.req.write) ? mem[idx] : '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= req_fire;   // Exactly one pulse per request
        end
    end

    assign bus.resp_valid = resp_valid_q;
    assign bus.resp       = resp_q;

endmodule

`default_nettype wire

// File: source/axi_ram_subsys.sv
/*
 * AXI4 RAM subsystem. A burst front end feeds a word SRAM over the system bus.
 * One transaction at a time. Writes win when AW and AR arrive together.
 * MEM_WORDS sets the SRAM depth in 32-bit words.
 */
`default_nettype none

module axi_ram_subsys #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_nrst,
    input  wire logic                              i_awvalid,
    input  wire logic [axi_pkg::AXI_ADDR_BITS-1:0] i_awaddr,
    input  wire logic [7:0]                        i_awlen,
    input  wire logic [2:0]                        i_awsize,
    input  wire axi_pkg::axi_burst_t               i_awburst,
    input  wire logic [axi_pkg::AXI_ID_BITS-1:0]   i_awid,
    output logic                                   o_awready,
    input  wire logic                              i_wvalid,
    input  wire logic [axi_pkg::AXI_DATA_BITS-1:0] i_wdata,
    input  wire logic [axi_pkg::AXI_STRB_BITS-1:0] i_wstrb,
    input  wire logic                              i_wlast,
    output logic                                   o_wready,
    output logic                                   o_bvalid,
    output axi_pkg::axi_resp_t                     o_bresp,
    output logic [axi_pkg::AXI_ID_BITS-1:0]        o_bid,
    input  wire logic                              i_bready,
    input  wire logic                              i_arvalid,
    input  wire logic [axi_pkg::AXI_ADDR_BITS-1:0] i_araddr,
    input  wire logic [7:0]                        i_arlen,
    input  wire logic [2:0]                        i_arsize,
    input  wire axi_pkg::axi_burst_t               i_arburst,
    input  wire logic [axi_pkg::AXI_ID_BITS-1:0]   i_arid,
    output logic                                   o_arready,
    output logic                                   o_rvalid,
    output logic [axi_pkg::AXI_DATA_BITS-1:0]      o_rdata,
    output axi_pkg::axi_resp_t                     o_rresp,
    output logic [axi_pkg::AXI_ID_BITS-1:0]        o_rid,
    output logic                                   o_rlast,
    input  wire logic                              i_rready
);
    import axi_pkg::*;
    import sysbus_pkg::*;

    // AXI addresses pass to the bus unchanged
    if (SYS_ADDR_BITS != AXI_ADDR_BITS) begin : g_addr_check
        $error("sysbus address width does not match the AXI address width");
    end

    sysbus_if bus ();

    // Stage 1, AXI bursts to single beats
    axi_burst_slave u_front (
        .*,
        .bus (bus.master)
    );

    // Stage 2, memory target
    sram_target #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .bus    (bus.target)
    );

endmodule

`default_nettype wire

// File: testbench/axi_ram_subsys_assertions.sv
/*
 * Protocol checks bound into the AXI RAM subsystem.
 * Covers B and R payload hold while stalled, rlast on beat arlen only,
 * and quiet handshake outputs in the first cycle out of reset.
 */
`default_nettype none

module axi_ram_subsys_assertions (
    input wire logic                              i_clk,
    input wire logic                              i_nrst,
    input wire logic                              o_awready,
    input wire logic                              o_wready,
    input wire logic                              i_arvalid,
    input wire logic                              o_arready,
    input wire logic [7:0]                        i_arlen,
    input wire logic                              o_bvalid,
    input wire logic                              i_bready,
    input wire logic [1:0]                        o_bresp,
    input wire logic [axi_pkg::AXI_ID_BITS-1:0]   o_bid,
    input wire logic                              o_rvalid,
    input wire logic                              i_rready,
    input wire logic [axi_pkg::AXI_DATA_BITS-1:0] o_rdata,
    input wire logic [1:0]                        o_rresp,
    input wire logic [axi_pkg::AXI_ID_BITS-1:0]   o_rid,
    input wire logic                              o_rlast
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fail_count = 0;   // Polled by the testbench
    logic [7:0]  arlen_q;
    logic [7:0]  rbeat_q;          // R beats taken in the current burst

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            arlen_q <= '0;
            rbeat_q <= '0;
        end else if (i_arvalid && o_arready) begin
            arlen_q <= i_arlen;
            rbeat_q <= '0;
        end else if (o_rvalid && i_rready) begin
            rbeat_q <= rbeat_q + 8'd1;
        end
    end

    b_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_bvalid && !i_bready |=> o_bvalid && $stable({o_bresp, o_bid}))
    else begin
        fail_count++;
        $error("B channel dropped or changed while stalled");
    end

    r_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_rvalid && !i_rready |=> o_rvalid && $stable({o_rdata, o_rresp, o_rid, o_rlast}))
    else begin
        fail_count++;
        $error("R channel dropped or changed while stalled");
    end

    // rlast exactly on beat arlen
    rlast_place: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_rvalid |-> (o_rlast == (rbeat_q == arlen_q)))
    else begin
        fail_count++;
        $error("rlast not on beat arlen");
    end

    reset_quiet: assert property (@(posedge i_clk)
        $rose(i_nrst) |-> !(o_awready || o_wready || o_arready || o_bvalid || o_rvalid))
    else begin
        fail_count++;
        $error("Handshake output high in the first cycle after reset");
    end

endmodule

bind axi_ram_subsys axi_ram_subsys_assertions u_assertions (.*);

`default_nettype wire

// File: testbench/tb_axi_ram_subsys.sv
/*
 * Testbench for the AXI4 RAM subsystem. All beats are 32 bits (size code 2).
 * MEM_WORDS is set to 1000 so a burst can run past the SRAM end inside one page.
 * A byte-strobed reference memory predicts every B and R beat.
 * Payload stability and rlast placement are checked by the bound assertions.
 */
`default_nettype none

module tb_axi_ram_subsys;
    timeunit 1ns;
    timeprecision 1ns;
    import axi_pkg::*;

    localparam int MEM_WORDS       = 1000;
    localparam int IDX_BITS        = $clog2(MEM_WORDS);
    localparam int CLK_PERIOD      = 100;
    localparam int NUM_BURSTS      = 16;
    localparam int MAX_BEATS       = 16;
    localparam int MARGIN          = 6;   // Cycles per beat, stalls included
    localparam int WATCHDOG_CYCLES = NUM_BURSTS * MAX_BEATS * MARGIN;

    logic                     i_clk = 1'b0;
    logic                     i_nrst;
    logic                     i_awvalid;
    logic [AXI_ADDR_BITS-1:0] i_awaddr;
    logic [7:0]               i_awlen;
    logic [2:0]               i_awsize;
    axi_burst_t               i_awburst;
    logic [AXI_ID_BITS-1:0]   i_awid;
    logic                     o_awready;
    logic                     i_wvalid;
    logic [AXI_DATA_BITS-1:0] i_wdata;
    logic [AXI_STRB_BITS-1:0] i_wstrb;
    logic                     i_wlast;
    logic                     o_wready;
    logic                     o_bvalid;
    axi_resp_t                o_bresp;
    logic [AXI_ID_BITS-1:0]   o_bid;
    logic                     i_bready;
    logic                     i_arvalid;
    logic [AXI_ADDR_BITS-1:0] i_araddr;
    logic [7:0]               i_arlen;
    logic [2:0]               i_arsize;
    axi_burst_t               i_arburst;
    logic [AXI_ID_BITS-1:0]   i_arid;
    logic                     o_arready;
    logic                     o_rvalid;
    logic [AXI_DATA_BITS-1:0] o_rdata;
    axi_resp_t                o_rresp;
    logic [AXI_ID_BITS-1:0]   o_rid;
    logic                     o_rlast;
    logic                     i_rready;

    logic [31:0] ref_mem [MEM_WORDS];   // Expected SRAM contents
    logic [31:0] seed = 32'h62b3;

    axi_ram_subsys #(
        .MEM_WORDS (MEM_WORDS)
    ) i_axi_ram_subsys (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] random_word();
        seed = seed * 32'd1664525 + 32'd1013904223;   // LCG step
        return seed;
    endfunction

    // High about three cycles in four
    function automatic logic random_ready();
        logic [31:0] r;
        r = random_word();
        return r[31] | r[30];
    endfunction

    // Beat address from the AXI burst rule, page bits untouched
    function automatic logic [15:0] next_addr(input logic [15:0] addr, input logic [7:0] len,
                                              input axi_burst_t burst);
        int span;
        int base;
        int off;
        span = 4 * (int'(len) + 1);
        off  = int'(addr[11:0]);
        if (burst == BURST_FIXED) begin
            return addr;
        end else if (burst == BURST_WRAP) begin
            base = off - (off % span);
            off  = base + ((off - base + 4) % span);
        end else begin
            off = (off + 4) % 4096;
        end
        return {addr[15:12], 12'(off)};
    endfunction

    // Returns 0 when the word lies past the SRAM
    function automatic logic model_write(input logic [15:0] addr, input logic [31:0] data,
                                         input logic [3:0] strb);
        logic [31:0] mask;
        int          word;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        word = int'(addr[15:2]);
        if (word >= MEM_WORDS) begin
            return 1'b0;
        end
        ref_mem[IDX_BITS'(word)] = (ref_mem[IDX_BITS'(word)] & ~mask) | (data & mask);
        return 1'b1;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic write_burst(input logic [15:0] addr, input logic [7:0] len,
                               input axi_burst_t burst, input logic [3:0] id,
                               input logic [3:0] strb);
        logic [15:0] a;
        int          beat;
        logic        err;
        logic        done;
        a    = addr;
        beat = 0;
        err  = 1'b0;
        done = 1'b0;
        @(posedge i_clk);
        i_awvalid <= 1'b1;
        i_awaddr  <= addr;
        i_awlen   <= len;
        i_awsize  <= 3'd2;
        i_awburst <= burst;
        i_awid    <= id;
        i_wvalid  <= 1'b1;   // First W beat rides with AW
        i_wdata   <= random_word();
        i_wstrb   <= strb;
        i_wlast   <= (len == 8'd0);
        while (beat <= int'(len)) begin
            @(posedge i_clk);
            if (i_awvalid && o_awready) begin
                i_awvalid <= 1'b0;
            end
            if (i_wvalid && o_wready) begin
                err  = err | !model_write(a, i_wdata, strb);
                a    = next_addr(a, len, burst);
                beat = beat + 1;
                if (beat <= int'(len)) begin
                    i_wdata <= random_word();
                    i_wlast <= (beat == int'(len));
                end else begin
                    i_wvalid <= 1'b0;
                    i_wlast  <= 1'b0;
                end
            end
        end
        i_bready <= random_ready();
        while (!done) begin
            @(posedge i_clk);
            if (o_bvalid && i_bready) begin
                expect_equal("o_bresp", 32'(err ? RESP_SLVERR : RESP_OKAY), 32'(o_bresp));
                expect_equal("o_bid", 32'(id), 32'(o_bid));
                done = 1'b1;
            end
            i_bready <= done ? 1'b0 : random_ready();
        end
    endtask

    task automatic read_burst(input logic [15:0] addr, input logic [7:0] len,
                              input axi_burst_t burst, input logic [3:0] id);
        logic [15:0] a;
        int          beat;
        logic        hit;
        a    = addr;
        beat = 0;
        @(posedge i_clk);
        i_arvalid <= 1'b1;
        i_araddr  <= addr;
        i_arlen   <= len;
        i_arsize  <= 3'd2;
        i_arburst <= burst;
        i_arid    <= id;
        i_rready  <= random_ready();
        while (beat <= int'(len)) begin
            @(posedge i_clk);
            if (i_arvalid && o_arready) begin
                i_arvalid <= 1'b0;
            end
            if (o_rvalid && i_rready) begin
                hit = int'(a[15:2]) < MEM_WORDS;
                expect_equal("o_rdata", hit ? ref_mem[IDX_BITS'(a[15:2])] : 32'h0, o_rdata);
                expect_equal("o_rresp", 32'(hit ? RESP_OKAY : RESP_SLVERR), 32'(o_rresp));
                expect_equal("o_rid", 32'(id), 32'(o_rid));
                expect_equal("o_rlast", 32'(beat == int'(len)), 32'(o_rlast));
                a    = next_addr(a, len, burst);
                beat = beat + 1;
            end
            i_rready <= (beat <= int'(len)) ? random_ready() : 1'b0;
        end
    endtask

    // Bound checker failures end the run at once
    always @(posedge i_clk) begin
        if (i_axi_ram_subsys.u_assertions.fail_count != 0) begin
            $display("A protocol assertion in the bound checker failed");
            $display("TEST FAIL");
            $fatal(1, "protocol assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout, the bursts did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        i_nrst    = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_awlen   = '0;
        i_awsize  = 3'd2;
        i_awburst = BURST_INCR;
        i_awid    = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_wlast   = 1'b0;
        i_bready  = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arlen   = '0;
        i_arsize  = 3'd2;
        i_arburst = BURST_INCR;
        i_arid    = '0;
        i_rready  = 1'b0;
        repeat (4) @(posedge i_clk);
        i_nrst <= 1'b1;
        write_burst(16'h0040, 8'd7, BURST_INCR, 4'h1, 4'hf);
        read_burst(16'h0040, 8'd7, BURST_INCR, 4'h2);
        write_burst(16'h0108, 8'd3, BURST_WRAP, 4'h3, 4'hf);   // Wraps back to 0x100
        read_burst(16'h0100, 8'd3, BURST_INCR, 4'h4);
        write_burst(16'h0200, 8'd3, BURST_FIXED, 4'h5, 4'hf);
        read_burst(16'h0200, 8'd0, BURST_INCR, 4'h6);
        write_burst(16'h0300, 8'd3, BURST_INCR, 4'h7, 4'hf);
        write_burst(16'h0300, 8'd3, BURST_INCR, 4'h8, 4'h5);
        write_burst(16'h0304, 8'd1, BURST_INCR, 4'h9, 4'h8);
        read_burst(16'h0300, 8'd3, BURST_INCR, 4'ha);
        write_burst(16'h0f98, 8'd3, BURST_INCR, 4'hb, 4'hf);   // Last two words past the end
        read_burst(16'h0f98, 8'd3, BURST_INCR, 4'hc);
        write_burst(16'h0ffc, 8'd1, BURST_INCR, 4'hd, 4'hf);   // Error first, then word 0
        read_burst(16'h0ffc, 8'd1, BURST_INCR, 4'he);
        write_burst(16'h0500, 8'd15, BURST_INCR, 4'hf, 4'hf);
        read_burst(16'h0500, 8'd15, BURST_INCR, 4'h0);
        repeat (2) @(posedge i_clk);
        if (i_axi_ram_subsys.u_assertions.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed during the run");
            $display("TEST FAIL");
            $fatal(1, "protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: axi_ram_subsys.f
source/axi_pkg.sv
source/sysbus_pkg.sv
source/sysbus_if.sv
source/axi_burst_slave.sv
source/sram_target.sv
source/axi_ram_subsys.sv
testbench/axi_ram_subsys_assertions.sv
testbench/tb_axi_ram_subsys.sv

// File: Makefile
# Verilator build for the AXI RAM subsystem testbench
VERILATOR  ?= verilator
TOP        ?= tb_axi_ram_subsys
FILELIST   ?= axi_ram_subsys.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ns
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --assert --timescale $(TIMESCALE) -j 0

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard source/*.sv testbench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
